/* list.f */
src/gf_pkg.sv
src/bch_pkg.sv
src/bch_word_in.sv
src/bch_syndrome.sv
src/bch_peterson.sv
src/bch_chien.sv
src/bch_word_out.sv
src/bch_decoder_top.sv
tb/bch_tb_pkg.sv
tb/bch_decoder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the BCH decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module bch_decoder_tb \
    -f list.f -o bch_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/bch_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* tb/bch_decoder_tb.sv */
`default_nettype none

module bch_decoder_tb
    import bch_pkg::*;
    import bch_tb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    bch_word_t in_word;
    logic in_req;
    logic in_ack;
    bch_word_t out_word;
    logic out_fail;
    logic out_req;
    logic out_ack;

    int value_errs = 0;
    int proto_errs = 0;
    int words_done = 0;
    int cycles = 0;

    // no errors, every single position, pairs with both ends, then triples
    // positions 0, 1 and 4 sum to zero in the field, so S1 is zero and S3 is not
    stim_t stim_tbl [tbl_size] = '{
        '{7'h00, 15'h0000, 2'd0}, '{7'h5a, 15'h0000, 2'd0}, '{7'h7f, 15'h0000, 2'd0},
        '{7'h01, 15'h0001, 2'd1}, '{7'h13, 15'h0002, 2'd1}, '{7'h26, 15'h0004, 2'd1},
        '{7'h3c, 15'h0008, 2'd1}, '{7'h45, 15'h0010, 2'd1}, '{7'h59, 15'h0020, 2'd1},
        '{7'h6e, 15'h0040, 2'd1}, '{7'h7f, 15'h0080, 2'd1}, '{7'h00, 15'h0100, 2'd1},
        '{7'h2b, 15'h0200, 2'd1}, '{7'h34, 15'h0400, 2'd1}, '{7'h4d, 15'h0800, 2'd1},
        '{7'h52, 15'h1000, 2'd1}, '{7'h61, 15'h2000, 2'd1}, '{7'h1f, 15'h4000, 2'd1},
        '{7'h3a, 15'h4001, 2'd2}, '{7'h00, 15'h0003, 2'd2}, '{7'h55, 15'h0410, 2'd2},
        '{7'h6c, 15'h2100, 2'd2}, '{7'h7f, 15'h6000, 2'd2},
        '{7'h11, 15'h4003, 2'd3}, '{7'h48, 15'h0013, 2'd3}, '{7'h2d, 15'h7000, 2'd3}
    };

    bch_decoder_top dut_i (
        .clk, .rst, .in_word, .in_req, .in_ack, .out_word, .out_fail, .out_req, .out_ack
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic proto_error(input string what);
        proto_errs++;
        $display("protocol violation at %0t, %s", $time, what);
    endtask

    // producer side of the input four-phase handshake
    task automatic send_word(input bch_word_t w);
        @(negedge clk);
        in_word = w;
        in_req  = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    // consumer side with ack after a random wait of 0 to 5 cycles
    task automatic take_word(output bch_word_t w, output logic fail);
        int delay;
        while (!out_req) @(negedge clk);
        delay = int'($urandom % 6);
        repeat (delay) @(negedge clk);
        w       = out_word;
        fail    = out_fail;
        out_ack = 1'b1;
        while (out_req) @(negedge clk);
        out_ack = 1'b0;
    endtask

    // handshake rules on values seen at the edge before the outputs update
    logic prev_in_req = 1'b0;
    logic prev_in_ack = 1'b0;
    logic prev_out_req = 1'b0;
    logic prev_out_ack = 1'b0;
    logic prev_out_fail = 1'b0;
    bch_word_t prev_out_word = '0;

    always @(posedge clk) begin
        if (!rst) begin
            if (in_ack && !prev_in_ack && !prev_in_req) begin
                proto_error("in_ack rose while in_req was low");
            end
            if (prev_out_req && !prev_out_ack) begin
                if (!out_req) begin
                    proto_error("out_req fell before out_ack rose");
                end else if (out_word !== prev_out_word || out_fail !== prev_out_fail) begin
                    proto_error("output word changed while out_req was high");
                end
            end
        end
        prev_in_req   = in_req;
        prev_in_ack   = in_ack;
        prev_out_req  = out_req;
        prev_out_ack  = out_ack;
        prev_out_word = out_word;
        prev_out_fail = out_fail;
    end

    // run limit
    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing the table", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bch_word_t cw;
        bch_word_t got_word;
        logic got_fail;
        int unsigned seed_ret;
        seed_ret = $urandom(rand_seed);
        rst     = 1'b1;
        in_word = '0;
        in_req  = 1'b0;
        out_ack = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("in_ack", 32'(in_ack), 32'd0);
        check("out_req", 32'(out_req), 32'd0);
        for (int i = 0; i < tbl_size; i++) begin
            cw = encode(stim_tbl[i].msg);
            send_word(cw ^ stim_tbl[i].mask);
            take_word(got_word, got_fail);
            words_done++;
            // up to two errors must be corrected
            if (stim_tbl[i].n_err <= 2'd2) begin
                check("out_word", 32'(got_word), 32'(cw));
                check("out_fail", 32'(got_fail), 32'd0);
            // three errors give a flag or some valid codeword
            end else if (!got_fail) begin
                check("out_word remainder", 32'(poly_rem(got_word)), 32'd0);
            // a flagged word leaves as received
            end else begin
                check("out_word", 32'(got_word), 32'(cw ^ stim_tbl[i].mask));
            end
        end
        $display("words %0d, value errors %0d, protocol errors %0d",
                 words_done, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/bch_tb_pkg.sv */
`default_nettype none

// reference model and stimulus format for the decoder testbench
package bch_tb_pkg;
    import bch_pkg::*;

    // words in the stimulus table
    parameter int tbl_size = 26;
    // seed for the out_ack delays
    parameter int unsigned rand_seed = 47275;
    // run limit in clock cycles
    parameter int timeout_cycles = tbl_size * 60;

    // one table entry, message plus injected errors
    typedef struct packed {
        logic [bch_k-1:0] msg;
        bch_word_t        mask;
        logic [1:0]       n_err;
    } stim_t;

    // non-systematic encoding, m(x) * g(x) without carries
    function automatic bch_word_t encode(logic [bch_k-1:0] msg);
        bch_word_t cw;
        cw = '0;
        for (int i = 0; i < bch_k; i++) begin
            if (msg[i]) begin
                cw = cw ^ (bch_word_t'(bch_gen_poly) << i);
            end
        end
        return cw;
    endfunction

    // remainder of w(x) mod g(x), zero for every codeword
    function automatic logic [bch_n-bch_k-1:0] poly_rem(bch_word_t w);
        bch_word_t r;
        r = w;
        // long division from the top degree down
        for (int i = bch_n - 1; i >= bch_n - bch_k; i--) begin
            if (r[i]) begin
                r = r ^ (bch_word_t'(bch_gen_poly) << (i - (bch_n - bch_k)));
            end
        end
        return r[bch_n-bch_k-1:0];
    endfunction

endpackage

`default_nettype wire

/* src/bch_decoder_top.sv */
`default_nettype none

module bch_decoder_top
    import bch_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire bch_word_t in_word,
    input  wire logic      in_req,
    output logic           in_ack,
    output bch_word_t      out_word,
    output logic           out_fail,
    output logic           out_req,
    input  wire logic      out_ack
);

    // captured word and decoder handshakes
    bch_word_t        rx_word;
    logic             syn_start;
    logic             out_done;

    // syndromes
    gf_pkg::gf_elem_t s1;
    gf_pkg::gf_elem_t s3;
    logic             syn_done;

    // locator
    gf_pkg::gf_elem_t sigma1;
    gf_pkg::gf_elem_t sigma2;
    logic [1:0]       err_count;
    logic             peterson_fail;
    logic             loc_done;

    // search result
    bch_word_t        err_pattern;
    logic             chien_fail;
    logic             chien_done;

    bch_word_in u_word_in (
        .clk, .rst, .in_word, .in_req, .in_ack, .out_done, .rx_word, .syn_start
    );

    bch_syndrome u_syndrome (
        .clk, .rst, .rx_word, .syn_start, .s1, .s3, .syn_done
    );

    bch_peterson u_peterson (
        .clk, .rst, .s1, .s3, .syn_done,
        .sigma1, .sigma2, .err_count, .peterson_fail, .loc_done
    );

    // one test per code position
    bch_chien #(.n_pos(bch_n)) u_chien (
        .clk, .rst, .sigma1, .sigma2, .err_count, .peterson_fail, .loc_done,
        .err_pattern, .chien_fail, .chien_done
    );

    bch_word_out u_word_out (
        .clk, .rst, .rx_word, .err_pattern, .chien_fail, .chien_done,
        .out_word, .out_fail, .out_req, .out_ack, .out_done
    );

endmodule

`default_nettype wire

/* src/bch_word_out.sv */
`default_nettype none

module bch_word_out
    import gf_pkg::*;
    import bch_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire bch_word_t rx_word,
    input  wire bch_word_t err_pattern,
    input  wire logic      chien_fail,
    input  wire logic      chien_done,
    output bch_word_t      out_word,
    output logic           out_fail,
    output logic           out_req,
    input  wire logic      out_ack,
    output logic           out_done
);

    // req already dropped and waiting for ack to fall
    logic ack_wait;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_req  <= 1'b0;
            ack_wait <= 1'b0;
            out_done <= 1'b0;
        end else begin
            out_done <= 1'b0;
            if (chien_done) begin
                out_req <= 1'b1;
            // consumer has taken the word
            end else if (out_req && out_ack) begin
                out_req  <= 1'b0;
                ack_wait <= 1'b1;
            // handshake closed so the input side may capture again
            end else if (ack_wait && !out_ack) begin
                ack_wait <= 1'b0;
                out_done <= 1'b1;
            end
        end
    end

    // correction by XOR of the error pattern
    // failed words carry a zero pattern and leave as received
    always_ff @(posedge clk) begin
        if (chien_done) begin
            out_word <= rx_word ^ err_pattern;
            out_fail <= chien_fail;
        end
    end

endmodule

`default_nettype wire

/* src/bch_chien.sv */
`default_nettype none

module bch_chien
    import gf_pkg::*;
    import bch_pkg::*;
#(
    parameter int n_pos = bch_n
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire gf_elem_t   sigma1,
    input  wire gf_elem_t   sigma2,
    input  wire logic [1:0] err_count,
    input  wire logic       peterson_fail,
    input  wire logic       loc_done,
    output bch_word_t       err_pattern,
    output logic            chien_fail,
    output logic            chien_done
);

    // per-position steps alpha^-1 and alpha^-2
    localparam gf_elem_t step1 = gf_inv(gf_alpha);
    localparam gf_elem_t step2 = gf_mul(step1, step1);

    // sigma1*x and sigma2*x^2 at x = alpha^-pos
    gf_elem_t   t1;
    gf_elem_t   t2;
    bch_pos_t   pos;
    logic       running;
    logic [1:0] hits;

    gf_elem_t   cur_t1;
    gf_elem_t   cur_t2;
    bch_pos_t   cur_pos;
    logic       hit;
    logic       last;
    logic       fail_next;
    logic [1:0] hits_next;

    // position 0 is tested straight from the locator inputs
    always_comb begin
        cur_t1    = loc_done ? sigma1 : t1;
        cur_t2    = loc_done ? sigma2 : t2;
        cur_pos   = loc_done ? '0 : pos;
        hit       = (gf_elem_t'(1) ^ cur_t1 ^ cur_t2) == '0;
        last      = cur_pos == bch_pos_t'(n_pos - 1);
        // at most two roots for a degree 2 locator
        hits_next = (loc_done ? 2'd0 : hits) + {1'b0, hit};
        // irreducible locator shows up as a short root count
        fail_next = peterson_fail || (hits_next != err_count);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos        <= '0;
            running    <= 1'b0;
            hits       <= '0;
            chien_fail <= 1'b0;
            chien_done <= 1'b0;
        end else begin
            chien_done <= 1'b0;
            if (loc_done || running) begin
                pos     <= cur_pos + 1'b1;
                hits    <= hits_next;
                running <= !last;
                if (last) begin
                    chien_done <= 1'b1;
                    chien_fail <= fail_next;
                end
            end
        end
    end

    // step the terms, collect flipped positions
    always_ff @(posedge clk) begin
        if (loc_done || running) begin
            t1 <= gf_mul(cur_t1, step1);
            t2 <= gf_mul(cur_t2, step2);
            if (last && fail_next) begin
                err_pattern <= '0;
            end else begin
                err_pattern <= (loc_done ? '0 : err_pattern)
                             | (hit ? bch_word_t'(1) << cur_pos : '0);
            end
        end
    end

endmodule

`default_nettype wire

/* src/bch_peterson.sv */
`default_nettype none

module bch_peterson
    import gf_pkg::*;
    import bch_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire gf_elem_t s1,
    input  wire gf_elem_t s3,
    input  wire logic     syn_done,
    output gf_elem_t      sigma1,
    output gf_elem_t      sigma2,
    output logic [1:0]    err_count,
    output logic          peterson_fail,
    output logic          loc_done
);

    // first stage results
    gf_elem_t s1_cube;
    gf_elem_t s1_inv;
    logic     stage2;

    // (S3 + S1^3) / S1
    gf_elem_t sig2_calc;

    assign sig2_calc = gf_mul(s3 ^ s1_cube, s1_inv);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage2   <= 1'b0;
            loc_done <= 1'b0;
        end else begin
            stage2   <= syn_done;
            loc_done <= stage2;
        end
    end

    // stage 1: cube and inverse of S1
    always_ff @(posedge clk) begin
        if (syn_done) begin
            s1_cube <= gf_pow(s1, 3);
            s1_inv  <= gf_inv(s1);
        end
    end

    // stage 2: locator coefficients
    always_ff @(posedge clk) begin
        if (stage2) begin
            if (s1 == '0) begin
                // sigma(x) = 1, nothing to flip
                sigma1        <= '0;
                sigma2        <= '0;
                err_count     <= 2'd0;
                // S3 alone cannot come from one or two errors
                peterson_fail <= (s3 != '0);
            end else begin
                sigma1        <= s1;
                sigma2        <= sig2_calc;
                peterson_fail <= 1'b0;
                // zero determinant term, drop to one error
                if (sig2_calc == '0) begin
                    err_count <= 2'd1;
                end else begin
                    err_count <= 2'(bch_t);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/bch_syndrome.sv */
`default_nettype none

module bch_syndrome
    import gf_pkg::*;
    import bch_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire bch_word_t rx_word,
    input  wire logic      syn_start,
    output gf_elem_t       s1,
    output gf_elem_t       s3,
    output logic           syn_done
);

    // evaluation points
    localparam gf_elem_t pt1 = gf_alpha;
    localparam gf_elem_t pt3 = gf_pow(gf_alpha, 3);

    bch_pos_t pos;
    logic     running;
    gf_elem_t bit_in;

    // current bit as a field element
    assign bit_in = gf_elem_t'(rx_word[pos]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos      <= '0;
            running  <= 1'b0;
            syn_done <= 1'b0;
        end else begin
            syn_done <= 1'b0;
            if (syn_start) begin
                // top bit is loaded with the start
                pos     <= bch_pos_t'(bch_n - 2);
                running <= 1'b1;
            end else if (running) begin
                pos <= pos - 1'b1;
                // bit 0 goes in on this edge
                if (pos == '0) begin
                    running  <= 1'b0;
                    syn_done <= 1'b1;
                end
            end
        end
    end

    // Horner: acc = acc * pt + r_i, highest degree first
    always_ff @(posedge clk) begin
        if (syn_start) begin
            s1 <= gf_elem_t'(rx_word[bch_n-1]);
            s3 <= gf_elem_t'(rx_word[bch_n-1]);
        end else if (running) begin
            s1 <= gf_mul(s1, pt1) ^ bit_in;
            s3 <= gf_mul(s3, pt3) ^ bit_in;
        end
    end

endmodule

`default_nettype wire

/* src/bch_word_in.sv */
`default_nettype none

module bch_word_in
    import gf_pkg::*;
    import bch_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire bch_word_t in_word,
    input  wire logic      in_req,
    output logic           in_ack,
    input  wire logic      out_done,
    output bch_word_t      rx_word,
    output logic           syn_start
);

    // one word in flight, held until the output side is done
    logic busy;
    logic take;

    // new request, previous handshake closed, decoder idle
    assign take = in_req && !in_ack && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack    <= 1'b0;
            syn_start <= 1'b0;
            busy      <= 1'b0;
        end else begin
            syn_start <= take;
            // ack rises on capture
            if (take) begin
                in_ack <= 1'b1;
            // return to zero once the producer drops req
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            // out_done never overlaps a capture
            if (take) begin
                busy <= 1'b1;
            end else if (out_done) begin
                busy <= 1'b0;
            end
        end
    end

    // received word, stable for the whole decode
    always_ff @(posedge clk) begin
        if (take) begin
            rx_word <= in_word;
        end
    end

endmodule

`default_nettype wire

/* src/bch_pkg.sv */
`default_nettype none

// binary BCH(15,7) with designed distance 5
package bch_pkg;

    // code length
    parameter int bch_n = 15;

    // message length
    parameter int bch_k = 7;

    // correctable errors per word
    parameter int bch_t = 2;

    // lcm of the minimal polynomials of alpha and alpha^3
    // x^8 + x^7 + x^6 + x^4 + 1
    parameter logic [bch_n-bch_k:0] bch_gen_poly = 9'b111010001;

    // bit i holds the coefficient of x^i
    typedef logic [bch_n-1:0] bch_word_t;

    // index of one bit in a word
    typedef logic [3:0] bch_pos_t;

endpackage

`default_nettype wire

/* src/gf_pkg.sv */
`default_nettype none

// arithmetic over GF(2^4) in polynomial basis
package gf_pkg;

    // bits per field symbol
    parameter int gf_width = 4;

    // x^4 + x + 1
    parameter logic [gf_width:0] gf_poly = 5'b10011;

    // primitive element x
    parameter logic [gf_width-1:0] gf_alpha = 4'b0010;

    typedef logic [gf_width-1:0] gf_elem_t;

    // shift-and-add multiply
    // reduce whenever the top bit falls out
    function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
        gf_elem_t acc;
        gf_elem_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < gf_width; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            // multiply sh by x
            if (sh[gf_width-1]) begin
                sh = gf_elem_t'(sh << 1) ^ gf_poly[gf_width-1:0];
            end else begin
                sh = gf_elem_t'(sh << 1);
            end
        end
        return acc;
    endfunction

    // repeated multiply, fixed loop bound
    // exponents above the group order are not needed here
    function automatic gf_elem_t gf_pow(gf_elem_t a, int unsigned e);
        gf_elem_t r;
        r = gf_elem_t'(1);
        for (int i = 0; i < (1 << gf_width) - 1; i++) begin
            if (i < e) begin
                r = gf_mul(r, a);
            end
        end
        return r;
    endfunction

    // a^-1 = a^(q-2) with q = 16
    // zero maps to zero, callers check for it
    function automatic gf_elem_t gf_inv(gf_elem_t a);
        return gf_pow(a, (1 << gf_width) - 2);
    endfunction

endpackage

`default_nettype wire
